/* rob_pkg.sv */
// Sizes, index types and bus structs shared by every block of the ordered read-return unit
// RTL files refer to these through rob_pkg:: scoped names
`default_nettype none

package rob_pkg;

    // ==============================
    // Sizes
    // ==============================

    // Reorder-buffer slots, the pointer logic relies on a power of two
    localparam int n_entries = 32;
    localparam int idx_bits = $clog2(n_entries);
    localparam int data_bits = 64;
    localparam int meta_bits = 8;
    localparam int addr_bits = 32;
    // Longest request in lines, which is also the most slots taken in one cycle
    localparam int max_alloc = 2;
    // Slots that must stay free for the issue stage to keep accepting
    localparam int min_free_slots = 2;

    // ==============================
    // Types
    // ==============================

    typedef logic [idx_bits-1:0] t_idx;
    typedef logic [$clog2(max_alloc):0] t_alloc_cnt;
    typedef logic [data_bits-1:0] t_data;
    typedef logic [meta_bits-1:0] t_meta;
    typedef logic [addr_bits-1:0] t_addr;

    // Read request from the user side
    typedef struct packed {
        t_addr addr;
        logic two_lines;
        t_meta meta;
    } t_read_req;

    // One line request to memory, tagged with its slot index
    typedef struct packed {
        t_addr addr;
        t_idx tag;
    } t_mem_req;

    // Memory response, returned in any order
    typedef struct packed {
        t_idx tag;
        t_data data;
    } t_mem_rsp;

    // Ordered output line with its user tag
    typedef struct packed {
        t_data data;
        t_meta meta;
    } t_read_out;

endpackage

`default_nettype wire

/* rob_ram_simple.sv */
// Simple dual-port RAM, one write port and one read port, for any payload type
// Writes land one cycle after they are presented and reads return one cycle after raddr
`timescale 1ns/1ps
`default_nettype none

module rob_ram_simple #(
    parameter int n_words = 32,
    parameter type t_word = logic
) (
    input  wire logic                       clk,
    input  wire logic                       wen,
    input  wire logic [$clog2(n_words)-1:0] waddr,
    input  wire t_word                      wdata,
    input  wire logic [$clog2(n_words)-1:0] raddr,
    output t_word                           rdata
);

    t_word mem [n_words];

    // Write request held for one cycle before it reaches the array
    logic                       wen_q;
    logic [$clog2(n_words)-1:0] waddr_q;
    t_word                      wdata_q;

    always_ff @(posedge clk)
    begin
        wen_q <= wen;
        waddr_q <= waddr;
        wdata_q <= wdata;

        if (wen_q)
        begin
            mem[waddr_q] <= wdata_q;
        end

        // Single output register on the read side
        rdata <= mem[raddr];
    end

endmodule

`default_nettype wire

/* rob_valid_bank.sv */
// One bank of single-bit valid flags that zeroes itself after reset
// rdy stays low until every word is cleared; reads return one cycle later
`timescale 1ns/1ps
`default_nettype none

module rob_valid_bank #(
    parameter int n_words = 16
) (
    input  wire logic                       clk,
    input  wire logic                       reset,
    output logic                            rdy,
    input  wire logic [$clog2(n_words)-1:0] raddr,
    output logic                            rdata,
    input  wire logic                       wen,
    input  wire logic [$clog2(n_words)-1:0] waddr,
    input  wire logic                       wdata
);

    logic                       mem [n_words];
    logic [$clog2(n_words)-1:0] init_idx;

    // Array write port, owned by the clear sweep until rdy rises
    logic                       mem_wen;
    logic [$clog2(n_words)-1:0] mem_waddr;
    logic                       mem_wdata;

    assign mem_wen = !rdy || wen;
    assign mem_waddr = rdy ? waddr : init_idx;
    assign mem_wdata = rdy ? wdata : 1'b0;

    // Clear sweep, one word per cycle
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            init_idx <= '0;
            rdy <= 1'b0;
        end
        else if (!rdy)
        begin
            init_idx <= init_idx + 1'b1;
            // Last word is written this cycle, so the bank is usable next cycle
            if (init_idx == ($clog2(n_words))'(n_words - 1))
            begin
                rdy <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (mem_wen)
        begin
            mem[mem_waddr] <= mem_wdata;
        end

        // A write to the word being read forwards the new value
        if (mem_wen && (mem_waddr == raddr))
        begin
            rdata <= mem_wdata;
        end
        else
        begin
            rdata <= mem[raddr];
        end
    end

endmodule

`default_nettype wire

/* rob_reorder.sv */
// Reorder buffer that takes out-of-order line responses and hands them back in slot order
// Slots are allocated with their meta, filled by tag and dequeued oldest first
`timescale 1ns/1ps
`default_nettype none

module rob_reorder (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire rob_pkg::t_alloc_cnt alloc,
    input  wire rob_pkg::t_meta     alloc_meta,
    output logic                    not_full,
    output rob_pkg::t_idx           alloc_idx,
    input  wire logic               enq_en,
    input  wire rob_pkg::t_mem_rsp  enq,
    input  wire logic               deq_en,
    output logic                    not_empty,
    output rob_pkg::t_data          first_data,
    output rob_pkg::t_meta          first_meta
);

    // Pointer width plus one bit so a full ring can be told from an empty one
    typedef logic [rob_pkg::idx_bits:0] t_idx_wide;

    rob_pkg::t_idx newest;
    rob_pkg::t_idx oldest;
    rob_pkg::t_idx oldest_q;
    logic [1:0]    bank_rdy;
    logic          banks_rdy;
    logic          newest_ge_oldest;

    assign banks_rdy = &bank_rdy;
    assign newest_ge_oldest = (newest >= oldest);

    // Headroom check against the oldest pointer, unwrapped by one bit
    assign not_full = banks_rdy &&
        (({1'b0, newest} + t_idx_wide'(rob_pkg::min_free_slots)) < {newest_ge_oldest, oldest});
    assign alloc_idx = newest;

    always_ff @(posedge clk)
    begin
        oldest_q <= oldest;
        if (reset)
        begin
            newest <= '0;
            oldest <= '0;
        end
        else
        begin
            newest <= newest + rob_pkg::t_idx'(alloc);
            if (deq_en)
            begin
                oldest <= oldest + 1'b1;
            end
        end
    end

    // ==============================
    // Valid bit tracking
    // ==============================

    // The meaning of a set valid bit flips every trip around the ring
    // The banks clear to 0, so the first trip looks for 1
    logic          valid_tag;
    logic          valid_tag_q;
    logic          enq_en_q;
    rob_pkg::t_idx enq_idx_q;
    logic          valid_wdata;

    always_ff @(posedge clk)
    begin
        valid_tag_q <= valid_tag;
        enq_idx_q <= enq.tag;
        if (reset)
        begin
            valid_tag <= 1'b1;
            enq_en_q <= 1'b0;
        end
        else
        begin
            enq_en_q <= enq_en;
            if (deq_en && (&oldest))
            begin
                valid_tag <= ~valid_tag;
            end
        end
    end

    // Slots below oldest already belong to the next trip and take the inverted tag
    assign valid_wdata = (enq_idx_q >= oldest_q) ? valid_tag_q : ~valid_tag_q;

    // Scan state, one index per bank, bank chosen by the low bit of the slot index
    logic [rob_pkg::idx_bits-2:0] scan_idx [2];
    logic                         scan_rdata [2];
    logic                         scan_bypass [2];
    logic                         scan_bank;
    logic                         scan_tgt;
    logic                         scan_set;
    logic                         scan_adv;
    logic [2:0]                   num_ready;

    // A write landing on the scanned word means that slot has just completed
    assign scan_set = (scan_rdata[scan_bank] == scan_tgt) || scan_bypass[scan_bank];
    // Stop counting before the small ready counter saturates
    assign scan_adv = banks_rdy && scan_set && (num_ready != 3'b111);

    always_ff @(posedge clk)
    begin
        if (scan_adv)
        begin
            scan_idx[scan_bank] <= scan_idx[scan_bank] + 1'b1;
            scan_bank <= ~scan_bank;
            // Bank 1 holds the last slot, so its wrap ends a trip
            if (scan_bank && (&scan_idx[1]))
            begin
                scan_tgt <= ~scan_tgt;
            end
        end
        if (reset || !banks_rdy)
        begin
            scan_idx[0] <= '0;
            scan_idx[1] <= '0;
            scan_bank <= 1'b0;
            scan_tgt <= 1'b1;
        end
    end

    // Ready entries waiting at the head, and not_empty as a registered level
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            num_ready <= '0;
            not_empty <= 1'b0;
        end
        else
        begin
            num_ready <= num_ready - 3'(deq_en) + 3'(scan_adv);
            not_empty <= scan_adv || (num_ready > 3'd1) || ((num_ready == 3'd1) && !deq_en);
        end
    end

    for (genvar p = 0; p < 2; p++)
    begin : g_bank
        logic bank_wen;

        assign bank_wen = enq_en_q && (enq_idx_q[0] == 1'(p));
        assign scan_bypass[p] = bank_wen && (enq_idx_q[rob_pkg::idx_bits-1:1] == scan_idx[p]);

        rob_valid_bank #(
            .n_words(rob_pkg::n_entries / 2)
        ) valid_bank (
            .clk  (clk),
            .reset(reset),
            .rdy  (bank_rdy[p]),
            .raddr(scan_idx[p]),
            .rdata(scan_rdata[p]),
            .wen  (bank_wen),
            .waddr(enq_idx_q[rob_pkg::idx_bits-1:1]),
            .wdata(valid_wdata)
        );
    end

    // ==============================
    // Storage
    // ==============================

    // Reading at oldest_q puts the head entry on the outputs two cycles after deq_en
    rob_ram_simple #(
        .n_words(rob_pkg::n_entries),
        .t_word (rob_pkg::t_data)
    ) data_ram (
        .clk  (clk),
        .wen  (enq_en),
        .waddr(enq.tag),
        .wdata(enq.data),
        .raddr(oldest_q),
        .rdata(first_data)
    );

    // A two-slot allocation writes its second meta copy in the following cycle
    // The issue stage takes no request in that cycle, so the write port is free
    logic           second_en;
    rob_pkg::t_idx  second_idx;
    rob_pkg::t_meta second_meta;
    logic           meta_wen;
    rob_pkg::t_idx  meta_waddr;
    rob_pkg::t_meta meta_wdata;

    always_ff @(posedge clk)
    begin
        second_idx <= newest + 1'b1;
        second_meta <= alloc_meta;
        if (reset)
        begin
            second_en <= 1'b0;
        end
        else
        begin
            second_en <= (alloc == rob_pkg::t_alloc_cnt'(2));
        end
    end

    assign meta_wen = (alloc != '0) || second_en;
    assign meta_waddr = second_en ? second_idx : newest;
    assign meta_wdata = second_en ? second_meta : alloc_meta;

    rob_ram_simple #(
        .n_words(rob_pkg::n_entries),
        .t_word (rob_pkg::t_meta)
    ) meta_ram (
        .clk  (clk),
        .wen  (meta_wen),
        .waddr(meta_waddr),
        .wdata(meta_wdata),
        .raddr(oldest_q),
        .rdata(first_meta)
    );

endmodule

`default_nettype wire

/* read_issue.sv */
// Issue stage, accepts read requests, allocates reorder slots and sends line requests
// Two-line requests go out as two consecutive memory requests on adjacent slots
`timescale 1ns/1ps
`default_nettype none

module read_issue (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire logic                req_en,
    input  wire rob_pkg::t_read_req  req,
    output logic                     req_ready,
    output rob_pkg::t_alloc_cnt      alloc,
    output rob_pkg::t_meta           alloc_meta,
    input  wire logic                not_full,
    input  wire rob_pkg::t_idx       alloc_idx,
    output logic                     mem_req_en,
    output rob_pkg::t_mem_req        mem_req
);

    logic          take;
    // Set while the second line of a request is still to be sent
    logic          pending;
    rob_pkg::t_addr addr_q;
    rob_pkg::t_idx tag_q;

    // The second line needs the memory port next cycle, so nothing new is taken
    assign req_ready = not_full && !pending;
    assign take = req_en && req_ready;

    assign alloc = !take ? rob_pkg::t_alloc_cnt'(0) :
                   req.two_lines ? rob_pkg::t_alloc_cnt'(2) : rob_pkg::t_alloc_cnt'(1);
    assign alloc_meta = req.meta;

    always_ff @(posedge clk)
    begin
        if (take)
        begin
            addr_q <= req.addr;
            tag_q <= alloc_idx;
            mem_req <= '{addr: req.addr, tag: alloc_idx};
        end
        else if (pending)
        begin
            // Line 1 sits on the next address and the next slot
            mem_req <= '{addr: addr_q + 1'b1, tag: tag_q + 1'b1};
        end

        if (reset)
        begin
            pending <= 1'b0;
            mem_req_en <= 1'b0;
        end
        else
        begin
            mem_req_en <= take || pending;
            pending <= take && req.two_lines;
        end
    end

endmodule

`default_nettype wire

/* read_return.sv */
// Return stage, drains completed entries in order while the output is enabled
// out_valid follows each dequeue by two cycles, matching the storage read latency
`timescale 1ns/1ps
`default_nettype none

module read_return (
    input  wire logic            clk,
    input  wire logic            reset,
    input  wire logic            out_en,
    input  wire logic            not_empty,
    output logic                 deq_en,
    input  wire rob_pkg::t_data  first_data,
    input  wire rob_pkg::t_meta  first_meta,
    output logic                 out_valid,
    output rob_pkg::t_read_out   out
);

    // Each bit marks a dequeue still on its way through storage
    logic [1:0] in_flight;

    assign deq_en = not_empty && out_en;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            in_flight <= '0;
        end
        else
        begin
            in_flight <= {in_flight[0], deq_en};
        end
    end

    assign out_valid = in_flight[1];
    assign out = '{data: first_data, meta: first_meta};

endmodule

`default_nettype wire

/* ordered_read_unit.sv */
// Ordered read-return unit, top level joining issue, reorder buffer and return stage
// Memory ports face an external memory that may answer in any order
`timescale 1ns/1ps
`default_nettype none

module ordered_read_unit (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire logic               req_en,
    input  wire rob_pkg::t_read_req req,
    output logic                    req_ready,
    output logic                    mem_req_en,
    output rob_pkg::t_mem_req       mem_req,
    input  wire logic               mem_rsp_en,
    input  wire rob_pkg::t_mem_rsp  mem_rsp,
    input  wire logic               out_en,
    output logic                    out_valid,
    output rob_pkg::t_read_out      out
);

    rob_pkg::t_alloc_cnt alloc;
    rob_pkg::t_meta      alloc_meta;
    logic                not_full;
    rob_pkg::t_idx       alloc_idx;
    logic                not_empty;
    logic                deq_en;
    rob_pkg::t_data      first_data;
    rob_pkg::t_meta      first_meta;

    read_issue issue0 (
        .clk       (clk),
        .reset     (reset),
        .req_en    (req_en),
        .req       (req),
        .req_ready (req_ready),
        .alloc     (alloc),
        .alloc_meta(alloc_meta),
        .not_full  (not_full),
        .alloc_idx (alloc_idx),
        .mem_req_en(mem_req_en),
        .mem_req   (mem_req)
    );

    // Responses go straight into the buffer, there is no back-pressure on them
    rob_reorder rob0 (
        .clk       (clk),
        .reset     (reset),
        .alloc     (alloc),
        .alloc_meta(alloc_meta),
        .not_full  (not_full),
        .alloc_idx (alloc_idx),
        .enq_en    (mem_rsp_en),
        .enq       (mem_rsp),
        .deq_en    (deq_en),
        .not_empty (not_empty),
        .first_data(first_data),
        .first_meta(first_meta)
    );

    read_return return0 (
        .clk       (clk),
        .reset     (reset),
        .out_en    (out_en),
        .not_empty (not_empty),
        .deq_en    (deq_en),
        .first_data(first_data),
        .first_meta(first_meta),
        .out_valid (out_valid),
        .out       (out)
    );

endmodule

`default_nettype wire

/* tb_mem_model.sv */
// Behavioral memory for the testbench, answering each line request after a random delay
// Responses leave at most one per cycle, so they come back out of request order
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model #(
    parameter rob_pkg::t_data data_mask = '0
) (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire logic              mem_req_en,
    input  wire rob_pkg::t_mem_req mem_req,
    output logic                   mem_rsp_en,
    output rob_pkg::t_mem_rsp      mem_rsp
);

    // Requests still waiting, each with the cycle from which it may be answered
    rob_pkg::t_mem_req pend_req [$];
    int unsigned       pend_due [$];
    int unsigned       cycle;

    // Line contents are the address repeated twice under a fixed mask
    function automatic rob_pkg::t_data line_data(input rob_pkg::t_addr addr);
        return {addr, addr} ^ data_mask;
    endfunction

    initial
    begin
        int pick;
        mem_rsp_en = 1'b0;
        mem_rsp = '0;
        cycle = 0;
        forever
        begin
            // Everything moves 1 ns after the edge, like the rest of the stimulus
            @(posedge clk);
            #1;
            cycle++;
            mem_rsp_en = 1'b0;
            if (reset)
            begin
                pend_req.delete();
                pend_due.delete();
            end
            else
            begin
                // The request registered at this edge gets a delay of 1 to 20 cycles
                if (mem_req_en)
                begin
                    pend_req.push_back(mem_req);
                    pend_due.push_back(cycle + $urandom_range(20, 1));
                end
                // First request in the list whose delay has run out is answered
                pick = -1;
                for (int i = 0; i < pend_req.size(); i++)
                begin
                    if ((pick < 0) && (pend_due[i] <= cycle))
                    begin
                        pick = i;
                    end
                end
                if (pick >= 0)
                begin
                    mem_rsp_en = 1'b1;
                    mem_rsp = '{tag: pend_req[pick].tag, data: line_data(pend_req[pick].addr)};
                    pend_req.delete(pick);
                    pend_due.delete(pick);
                end
            end
        end
    end

endmodule

`default_nettype wire

/* tb_ordered_read_unit.sv */
// Testbench for the ordered read-return unit that runs directed tests against a memory model
// Expected lines are queued in acceptance order and compared on every out_valid
`timescale 1ns/1ps
`default_nettype none

module tb_ordered_read_unit;

    localparam int clk_period = 100;
    localparam rob_pkg::t_data line_mask = 64'h5a3c_96f0_0ff0_c3a5;
    localparam int max_outstanding = rob_pkg::n_entries - rob_pkg::min_free_slots;
    // Upper bound on the lines offered by all tests together
    localparam int max_lines = 20 + 20 + 40 + 400;
    localparam int watchdog_cycles = max_lines * 40 + 2000;

    logic                clk;
    logic                reset;
    logic                req_en;
    rob_pkg::t_read_req  req;
    logic                req_ready;
    logic                mem_req_en;
    rob_pkg::t_mem_req   mem_req;
    logic                mem_rsp_en;
    rob_pkg::t_mem_rsp   mem_rsp;
    logic                out_en;
    logic                out_valid;
    rob_pkg::t_read_out  out;

    rob_pkg::t_read_out  expect_q [$];
    rob_pkg::t_read_out  exp_out;
    int                  n_checks = 0;
    int                  n_errors = 0;
    int                  n_outputs = 0;
    int                  n_lines = 0;
    int unsigned         seed;

    ordered_read_unit dut0 (
        .clk       (clk),
        .reset     (reset),
        .req_en    (req_en),
        .req       (req),
        .req_ready (req_ready),
        .mem_req_en(mem_req_en),
        .mem_req   (mem_req),
        .mem_rsp_en(mem_rsp_en),
        .mem_rsp   (mem_rsp),
        .out_en    (out_en),
        .out_valid (out_valid),
        .out       (out)
    );

    tb_mem_model #(
        .data_mask(line_mask)
    ) mem0 (
        .clk       (clk),
        .reset     (reset),
        .mem_req_en(mem_req_en),
        .mem_req   (mem_req),
        .mem_rsp_en(mem_rsp_en),
        .mem_rsp   (mem_rsp)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(clk_period / 2) clk = ~clk;
        end
    end

    // ==============================
    // Checking helpers
    // ==============================

    // Contents the memory model holds for a line address
    function automatic rob_pkg::t_data expected_line(input rob_pkg::t_addr addr);
        return {addr, addr} ^ line_mask;
    endfunction

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        n_checks++;
        assert (got === exp)
        else
        begin
            $display("FAIL at %0d ns: %s is %h, expected %h", $time, name, got, exp);
            n_errors++;
        end
    endtask

    task automatic check_condition(input bit ok, input string what);
        n_checks++;
        assert (ok)
        else
        begin
            $display("ERROR at %0d ns: %s", $time, what);
            n_errors++;
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        $display("Test %s finished with %0d errors", name, n_errors - errors_before);
    endtask

    // Every output pulse takes the next expected line and is sampled at the falling edge
    always @(negedge clk)
    begin
        if (!reset && out_valid)
        begin
            n_outputs++;
            check_condition(expect_q.size() != 0, "out_valid pulsed with no line expected");
            if (expect_q.size() != 0)
            begin
                exp_out = expect_q.pop_front();
                compare_value("out.data", out.data, exp_out.data);
                compare_value("out.meta", out.meta, exp_out.meta);
            end
        end
    end

    // ==============================
    // Stimulus tasks
    // ==============================

    // Holds a request for up to max_wait cycles
    // Returns 1 ns after the edge that ends it
    task automatic offer_request(input rob_pkg::t_addr addr, input logic two_lines,
                                 input rob_pkg::t_meta meta, input int max_wait,
                                 output bit taken);
        int waited;
        rob_pkg::t_addr line_addr;
        waited = 0;
        req_en = 1'b1;
        req = '{addr: addr, two_lines: two_lines, meta: meta};
        @(negedge clk);
        while (!req_ready && (waited < max_wait))
        begin
            @(negedge clk);
            waited++;
        end
        // req_ready is stable here, so the next edge takes the request
        taken = req_ready;
        @(posedge clk);
        #1;
        req_en = 1'b0;
        if (taken)
        begin
            for (int k = 0; k < (two_lines ? 2 : 1); k++)
            begin
                line_addr = addr + rob_pkg::t_addr'(k);
                expect_q.push_back('{data: expected_line(line_addr), meta: meta});
                n_lines++;
            end
        end
    endtask

    task automatic send_request(input rob_pkg::t_addr addr, input logic two_lines,
                                input rob_pkg::t_meta meta);
        bit taken;
        offer_request(addr, two_lines, meta, 1000, taken);
        check_condition(taken, "request not accepted within 1000 cycles");
    endtask

    // Waits until every expected line came out, then a few more cycles for strays
    task automatic wait_drain(input int max_cycles);
        int waited;
        waited = 0;
        while ((expect_q.size() != 0) && (waited < max_cycles))
        begin
            @(posedge clk);
            waited++;
        end
        check_condition(expect_q.size() == 0, "expected lines never came out");
        repeat (4) @(posedge clk);
        #1;
    endtask

    // ==============================
    // Directed tests
    // ==============================

    task automatic check_reset_state();
        int errors_before;
        int waited;
        errors_before = n_errors;
        @(negedge clk);
        compare_value("out_valid", out_valid, 1'b0);
        compare_value("mem_req_en", mem_req_en, 1'b0);
        compare_value("req_ready", req_ready, 1'b0);
        // The valid banks clear themselves, then req_ready rises on its own
        waited = 0;
        while (!req_ready && (waited < 4 * rob_pkg::n_entries))
        begin
            @(negedge clk);
            waited++;
        end
        check_condition(req_ready, "req_ready never rose after reset");
        @(posedge clk);
        #1;
        finish_test("reset state", errors_before);
    endtask

    task automatic stream_single_lines();
        int errors_before;
        errors_before = n_errors;
        out_en = 1'b1;
        for (int i = 0; i < 20; i++)
        begin
            send_request(32'h0000_1000 + 32'(i * 3), 1'b0, 8'(8'h40 + i));
        end
        wait_drain(2000);
        finish_test("single-line stream", errors_before);
    endtask

    task automatic stream_two_lines();
        int errors_before;
        rob_pkg::t_addr addr;
        rob_pkg::t_idx first_tag;
        errors_before = n_errors;
        for (int i = 0; i < 10; i++)
        begin
            addr = 32'h0002_0000 + 32'(i * 16);
            send_request(addr, 1'b1, 8'(8'h80 + i));
            // Slots are handed out one per accepted line, starting at slot 0 after reset
            first_tag = rob_pkg::t_idx'(n_lines - 2);
            // Line 0 is on the memory port in the cycle after acceptance and line 1 after that
            @(negedge clk);
            compare_value("mem_req_en", mem_req_en, 1'b1);
            compare_value("mem_req.addr", mem_req.addr, addr);
            compare_value("mem_req.tag", mem_req.tag, first_tag);
            @(negedge clk);
            compare_value("mem_req_en", mem_req_en, 1'b1);
            compare_value("mem_req.addr", mem_req.addr, rob_pkg::t_addr'(addr + 1));
            compare_value("mem_req.tag", mem_req.tag, rob_pkg::t_idx'(first_tag + 1'b1));
            @(posedge clk);
            #1;
        end
        wait_drain(2000);
        finish_test("two-line requests", errors_before);
    endtask

    task automatic fill_with_output_stalled();
        int errors_before;
        int accepted;
        int outputs_before;
        bit taken;
        errors_before = n_errors;
        accepted = 0;
        outputs_before = n_outputs;
        out_en = 1'b0;
        for (int i = 0; i < 40; i++)
        begin
            offer_request(32'h0003_0000 + 32'(i), 1'b0, 8'(i), 40, taken);
            if (taken)
            begin
                accepted++;
            end
        end
        // Every accepted line has been answered by now but must still be held back
        repeat (40) @(posedge clk);
        #1;
        compare_value("accepted requests", accepted, max_outstanding);
        compare_value("outputs with out_en low", n_outputs - outputs_before, 0);
        out_en = 1'b1;
        wait_drain(2000);
        finish_test("output stall", errors_before);
    endtask

    task automatic mixed_long_run();
        int errors_before;
        int gap;
        rob_pkg::t_addr addr;
        logic two_lines;
        rob_pkg::t_meta meta;
        bit taken;
        errors_before = n_errors;
        for (int i = 0; i < 200; i++)
        begin
            addr = $urandom();
            two_lines = 1'($urandom_range(1, 0));
            meta = 8'($urandom_range(255, 0));
            // Output stalls come in runs of several requests
            if ($urandom_range(7, 0) == 0)
            begin
                out_en = ~out_en;
            end
            offer_request(addr, two_lines, meta, 30, taken);
            if (!taken)
            begin
                // The buffer filled during a stall, so open the output and offer again
                out_en = 1'b1;
                send_request(addr, two_lines, meta);
            end
            gap = $urandom_range(2, 0);
            repeat (gap)
            begin
                @(posedge clk);
                #1;
            end
        end
        out_en = 1'b1;
        wait_drain(4000);
        finish_test("mixed long run", errors_before);
    endtask

    // ==============================
    // Main sequence and watchdog
    // ==============================

    initial
    begin
        // Fixed seed for the random stimulus
        seed = $urandom(68);
        reset = 1'b1;
        req_en = 1'b0;
        req = '0;
        out_en = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;

        check_reset_state();
        stream_single_lines();
        stream_two_lines();
        fill_with_output_stalled();
        mixed_long_run();
        compare_value("output count", n_outputs, n_lines);

        $display("Checks %0d, errors %0d, outputs %0d, lines %0d",
                 n_checks, n_errors, n_outputs, n_lines);
        if (n_errors == 0)
        begin
            $display("TESTBENCH PASSED");
        end
        else
        begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // Run length bound scales with the number of lines the tests can offer
    initial
    begin
        #(watchdog_cycles * clk_period);
        $display("ERROR at %0d ns: watchdog expired before the tests finished", $time);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* ordered_read_unit.f */
rob_pkg.sv
rob_ram_simple.sv
rob_valid_bank.sv
rob_reorder.sv
read_issue.sv
read_return.sv
ordered_read_unit.sv
tb_mem_model.sv
tb_ordered_read_unit.sv
